/* dv/cpuTb.sv */
// Testbench for the pipelined core: loads the test file, models both memories and checks stores.

`timescale 1ns/1ps

`include "core_params.svh"

module cpuTb;

  logic        clk = 1'b0;
  logic        reset;
  logic [31:0] instruction;
  logic [31:0] instructionAddress;
  logic [31:0] dataIn;
  logic [31:0] dataMemAddress;
  logic [31:0] dataOut;
  logic        toMemWriteEnable;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];

  int          progLen;
  int          storeIndex = 0;
  int          errors = 0;
  int          cycles = 0;
  int          timeoutLimit = 1000;
  int          drain;
  bit          loadOk;
  logic [31:0] endAddress;

  cpu cpu_i (
    .clk(clk),
    .reset(reset),
    .instruction(instruction),
    .instructionAddress(instructionAddress),
    .dataIn(dataIn),
    .dataMemAddress(dataMemAddress),
    .dataOut(dataOut),
    .toMemWriteEnable(toMemWriteEnable)
  );

  always #20 clk = ~clk;

  // Both memories answer in the same cycle as their address.
  assign instruction = imem[instructionAddress[9:2]];
  assign dataIn      = dmem[dataMemAddress[9:2]];

  always @(posedge clk) begin
    if (toMemWriteEnable) begin
      dmem[dataMemAddress[9:2]] <= dataOut;
    end
  end

  // Run limit counts cycles after reset.
  always @(posedge clk) begin
    if (!reset) begin
      cycles <= cycles + 1;
      if (cycles >= timeoutLimit) begin
        $display("Timeout: program did not complete within %0d cycles", timeoutLimit);
        $display("Verification failed");
        $finish;
      end
    end
  end

  task automatic loadTests(output bit ok);
    int          fd;
    int          n;
    string       line;
    logic [7:0]  kind;
    logic [31:0] a;
    logic [31:0] b;
    // Unloaded instruction words are no-ops, data words carry their address.
    for (int i = 0; i < 256; i++) begin
      imem[i] = `CORE_NOP;
      dmem[i] = {16'hA5A5, 6'd0, i[7:0], 2'b00};
    end
    progLen = 0;
    ok = 1'b0;
    fd = $fopen("dv/cpu_tests.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%c %h %h", kind, a, b);
        if (n >= 2 && kind == "I") begin
          imem[progLen[7:0]] = a;
          progLen++;
        end else if (n == 3 && kind == "D") begin
          dmem[a[9:2]] = b;
        end else if (n == 3 && kind == "S") begin
          expAddr.push_back(a);
          expData.push_back(b);
        end
      end
      $fclose(fd);
    end
    timeoutLimit = progLen + 40;
  endtask

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected) begin
      $display("FAIL at time %0t: %s expected %h, got %h", $time, what, expected, actual);
      errors++;
    end
  endtask

  task automatic checkStore();
    if (toMemWriteEnable) begin
      if (storeIndex >= expAddr.size()) begin
        $display("Unexpected extra store to address %h at time %0t", dataMemAddress, $time);
        errors++;
      end else begin
        compare(dataMemAddress, expAddr[storeIndex], "store address");
        compare(dataOut, expData[storeIndex], "store data");
        storeIndex++;
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    loadTests(loadOk);
    if (!loadOk) begin
      $display("Test file dv/cpu_tests.txt could not be opened");
      $display("Verification failed");
      $finish;
    end else begin
      endAddress = progLen << 2;
      // No store may appear while reset is held.
      repeat (15) begin
        @(negedge clk);
        if (toMemWriteEnable) begin
          $display("Store enable was high during reset at time %0t", $time);
          errors++;
        end
      end
      @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      compare(instructionAddress, `CORE_RESET_PC, "PC after reset");
      // Run until fetch passes the program end, then let the pipeline drain.
      drain = 0;
      while (drain < 6) begin
        checkStore();
        if (drain > 0 || instructionAddress == endAddress) begin
          drain++;
        end
        @(negedge clk);
      end
      if (storeIndex < expAddr.size()) begin
        $display("Missing stores: only %0d of %0d expected stores were seen",
                 storeIndex, expAddr.size());
        errors++;
      end
      $display("Stores checked: %0d, errors: %0d", storeIndex, errors);
      if (errors == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
      $finish;
    end
  end

endmodule

/* dv/cpu_tests.txt */
# Records: I <instruction word hex> | D <byte address> <preset word> | S <byte address> <word>
# S records list the expected stores in the order the core must issue them.
D 00000080 00001000
I 20010007  # addi r1, r0, 7
I 2002000C  # addi r2, r0, 12
I 2003FFFB  # addi r3, r0, -5
I 8C050080  # lw   r5, 0x80(r0)
I 00222020  # add  r4, r1, r2
I 00223022  # sub  r6, r1, r2
I 00223824  # and  r7, r1, r2
I AC040100  # sw   r4, 0x100(r0)
I AC060104  # sw   r6, 0x104(r0)
I AC070108  # sw   r7, 0x108(r0)
I 00224025  # or   r8, r1, r2
I 0061482A  # slt  r9, r3, r1
I 0023502A  # slt  r10, r1, r3
I AC08010C  # sw   r8, 0x10C(r0)
I AC090110  # sw   r9, 0x110(r0)
I AC0A0114  # sw   r10, 0x114(r0)
I 20ABFFFD  # addi r11, r5, -3
I 20200005  # addi r0, r1, 5
I 10220008  # beq  r1, r2, 8 (not taken)
I AC0B0118  # sw   r11, 0x118(r0)
I AC00011C  # sw   r0, 0x11C(r0)
I 10210005  # beq  r1, r1, 5 (taken)
I AC010120  # sw   r1, 0x120(r0) delay
I AC020124  # sw   r2, 0x124(r0) delay
I AC030128  # sw   r3, 0x128(r0) delay
I AC04012C  # sw   r4, 0x12C(r0) skipped
I AC040130  # sw   r4, 0x130(r0) skipped
I AC020134  # sw   r2, 0x134(r0) branch target
S 00000100 00000013
S 00000104 FFFFFFFB
S 00000108 00000004
S 0000010C 0000000F
S 00000110 00000001
S 00000114 00000000
S 00000118 00000FFD
S 0000011C 00000000
S 00000120 00000007
S 00000124 0000000C
S 00000128 FFFFFFFB
S 00000134 0000000C

/* logic/controlDecoder.sv */
// Combinational decoder turning the word in decode into control levels for execute.

`timescale 1ns/1ps

module controlDecoder (
  input  isaPkg::instrWordT instructionId,
  decodeCtrlIfc.decoder     ctrl
);

  pipePkg::ctrlT decoded;

  always_comb begin
    // Inactive controls unless a known code matches.
    decoded            = '0;
    decoded.aluControl = isaPkg::ALU_ADD;

    case (instructionId.register.opcode)
      isaPkg::OP_RTYPE: begin
        decoded.regWrite = 1'b1;
        decoded.regDst   = 1'b1;
        case (instructionId.register.funct)
          isaPkg::FN_ADD: decoded.aluControl = isaPkg::ALU_ADD;
          isaPkg::FN_SUB: decoded.aluControl = isaPkg::ALU_SUB;
          isaPkg::FN_AND: decoded.aluControl = isaPkg::ALU_AND;
          isaPkg::FN_OR:  decoded.aluControl = isaPkg::ALU_OR;
          isaPkg::FN_SLT: decoded.aluControl = isaPkg::ALU_SLT;
          default: begin
            decoded.regWrite = 1'b0;
            decoded.regDst   = 1'b0;
          end
        endcase
      end
      isaPkg::OP_ADDI: begin
        decoded.regWrite = 1'b1;
        decoded.aluSrc   = 1'b1;
      end
      isaPkg::OP_LW: begin
        decoded.regWrite = 1'b1;
        decoded.memToReg = 1'b1;
        decoded.aluSrc   = 1'b1;
      end
      isaPkg::OP_SW: begin
        decoded.memWrite = 1'b1;
        decoded.aluSrc   = 1'b1;
      end
      isaPkg::OP_BEQ: begin
        // Equality shows up as a zero difference.
        decoded.branch     = 1'b1;
        decoded.aluControl = isaPkg::ALU_SUB;
      end
      default: ;
    endcase
  end

  assign ctrl.regWrite   = decoded.regWrite;
  assign ctrl.memToReg   = decoded.memToReg;
  assign ctrl.memWrite   = decoded.memWrite;
  assign ctrl.branch     = decoded.branch;
  assign ctrl.aluControl = decoded.aluControl;
  assign ctrl.aluSrc     = decoded.aluSrc;
  assign ctrl.regDst     = decoded.regDst;

endmodule

/* logic/core_params.svh */
// Core-wide constants for the pipelined MIPS core, included by fetch, register file and testbench.

`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Address loaded into the PC by reset.
`define CORE_RESET_PC 32'h0000_0000

// Number of architectural registers.
`define CORE_REG_COUNT 32

// All-zero word of R-type form.
// The decoder gives it no active controls, so it does nothing.
// Fetch puts it in decode on reset.
`define CORE_NOP 32'h0000_0000

`endif

/* logic/cpu.sv */
// Top level of the pipelined core, wiring the stages to external instruction and data memory.

`timescale 1ns/1ps

module cpu (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] instruction,
  output logic [31:0] instructionAddress,
  input  logic [31:0] dataIn,
  output logic [31:0] dataMemAddress,
  output logic [31:0] dataOut,
  output logic        toMemWriteEnable
);

  isaPkg::instrWordT instructionId;
  logic [31:0]       pcPlus4Id;
  logic              pcSource;
  logic [31:0]       branchTarget;
  logic [31:0]       readData1;
  logic [31:0]       readData2;
  logic              regWrite;
  logic [4:0]        writeReg;
  logic [31:0]       result;

  decodeCtrlIfc ctrlBus ();

  instructionFetch fetch (
    .clk(clk),
    .reset(reset),
    .pcSource(pcSource),
    .branchTarget(branchTarget),
    .instruction(instruction),
    .instructionAddress(instructionAddress),
    .instructionId(instructionId),
    .pcPlus4Id(pcPlus4Id)
  );

  controlDecoder decoder (
    .instructionId(instructionId),
    .ctrl(ctrlBus.decoder)
  );

  registerFile regs (
    .clk(clk),
    .reset(reset),
    .readReg1(instructionId.register.rs),
    .readReg2(instructionId.register.rt),
    .readData1(readData1),
    .readData2(readData2),
    .regWrite(regWrite),
    .writeReg(writeReg),
    .writeData(result)
  );

  executeUnit execute (
    .clk(clk),
    .reset(reset),
    .ctrl(ctrlBus.execute),
    .instructionId(instructionId),
    .pcPlus4Id(pcPlus4Id),
    .readData1(readData1),
    .readData2(readData2),
    .dataIn(dataIn),
    .dataMemAddress(dataMemAddress),
    .dataOut(dataOut),
    .toMemWriteEnable(toMemWriteEnable),
    .pcSource(pcSource),
    .branchTarget(branchTarget),
    .regWrite(regWrite),
    .writeReg(writeReg),
    .result(result)
  );

endmodule

/* logic/decodeCtrlIfc.sv */
// Control levels passed from the decoder to the execute unit, valid for the whole cycle.

`timescale 1ns/1ps

interface decodeCtrlIfc;
  logic           regWrite;
  logic           memToReg;
  logic           memWrite;
  logic           branch;
  isaPkg::aluCmdT aluControl;
  logic           aluSrc;
  logic           regDst;

  modport decoder (
    output regWrite, memToReg, memWrite, branch,
    output aluControl, aluSrc, regDst
  );

  modport execute (
    input regWrite, memToReg, memWrite, branch,
    input aluControl, aluSrc, regDst
  );

endinterface

/* logic/executeUnit.sv */
// Execute, memory access and write-back stages with their pipeline registers and the ALU.

`timescale 1ns/1ps

module executeUnit (
  input  logic              clk,
  input  logic              reset,
  decodeCtrlIfc.execute     ctrl,
  input  isaPkg::instrWordT instructionId,
  input  logic [31:0]       pcPlus4Id,
  input  logic [31:0]       readData1,
  input  logic [31:0]       readData2,
  input  logic [31:0]       dataIn,
  output logic [31:0]       dataMemAddress,
  output logic [31:0]       dataOut,
  output logic              toMemWriteEnable,
  output logic              pcSource,
  output logic [31:0]       branchTarget,
  output logic              regWrite,
  output logic [4:0]        writeReg,
  output logic [31:0]       result
);

  pipePkg::idExT  idEx;
  pipePkg::idExT  idExNext;
  pipePkg::exMemT exMem;
  pipePkg::exMemT exMemNext;
  pipePkg::memWbT memWb;
  pipePkg::memWbT memWbNext;

  logic [31:0] srcB;
  logic [31:0] aluOut;

  // Decode to execute.
  always_comb begin
    idExNext.ctrl.regWrite   = ctrl.regWrite;
    idExNext.ctrl.memToReg   = ctrl.memToReg;
    idExNext.ctrl.memWrite   = ctrl.memWrite;
    idExNext.ctrl.branch     = ctrl.branch;
    idExNext.ctrl.aluControl = ctrl.aluControl;
    idExNext.ctrl.aluSrc     = ctrl.aluSrc;
    idExNext.ctrl.regDst     = ctrl.regDst;
    idExNext.readData1       = readData1;
    idExNext.readData2       = readData2;
    idExNext.rt              = instructionId.immediate.rt;
    idExNext.rd              = instructionId.register.rd;
    idExNext.signImm         = {{16{instructionId.immediate.imm[15]}},
                                instructionId.immediate.imm};
    idExNext.pcPlus4         = pcPlus4Id;
  end

  always_ff @(posedge clk) begin
    idEx <= idExNext;
    if (reset) begin
      idEx.ctrl.regWrite <= 1'b0;
      idEx.ctrl.memWrite <= 1'b0;
      idEx.ctrl.branch   <= 1'b0;
    end
  end

  // Execute.
  assign srcB = idEx.ctrl.aluSrc ? idEx.signImm : idEx.readData2;

  always_comb begin
    case (idEx.ctrl.aluControl)
      isaPkg::ALU_ADD: aluOut = idEx.readData1 + srcB;
      isaPkg::ALU_SUB: aluOut = idEx.readData1 - srcB;
      isaPkg::ALU_AND: aluOut = idEx.readData1 & srcB;
      isaPkg::ALU_OR:  aluOut = idEx.readData1 | srcB;
      isaPkg::ALU_SLT: aluOut = {31'd0, $signed(idEx.readData1) < $signed(srcB)};
      default:         aluOut = 32'd0;
    endcase
  end

  always_comb begin
    exMemNext.regWrite  = idEx.ctrl.regWrite;
    exMemNext.memToReg  = idEx.ctrl.memToReg;
    exMemNext.memWrite  = idEx.ctrl.memWrite;
    exMemNext.branch    = idEx.ctrl.branch;
    exMemNext.zero      = (aluOut == 32'd0);
    exMemNext.aluOut    = aluOut;
    exMemNext.writeData = idEx.readData2;
    // R-type writes rd, immediate forms write rt.
    exMemNext.writeReg  = idEx.ctrl.regDst ? idEx.rd : idEx.rt;
    // Word offset relative to the next instruction.
    exMemNext.pcBranch  = idEx.pcPlus4 + {idEx.signImm[29:0], 2'b00};
  end

  always_ff @(posedge clk) begin
    exMem <= exMemNext;
    if (reset) begin
      exMem.regWrite <= 1'b0;
      exMem.memWrite <= 1'b0;
      exMem.branch   <= 1'b0;
    end
  end

  // Memory access.
  assign dataMemAddress   = exMem.aluOut;
  assign dataOut          = exMem.writeData;
  assign toMemWriteEnable = exMem.memWrite;
  assign pcSource         = exMem.branch & exMem.zero;
  assign branchTarget     = exMem.pcBranch;

  always_comb begin
    memWbNext.regWrite = exMem.regWrite;
    memWbNext.memToReg = exMem.memToReg;
    memWbNext.aluOut   = exMem.aluOut;
    memWbNext.readData = dataIn;
    memWbNext.writeReg = exMem.writeReg;
  end

  always_ff @(posedge clk) begin
    memWb <= memWbNext;
    if (reset) begin
      memWb.regWrite <= 1'b0;
    end
  end

  // Write-back.
  assign regWrite = memWb.regWrite;
  assign writeReg = memWb.writeReg;
  assign result   = memWb.memToReg ? memWb.readData : memWb.aluOut;

  storeNeverWritesRegister: assert property (
    @(posedge clk) disable iff (reset)
    !(exMem.memWrite && exMem.regWrite)
  ) else $error("store and register write both set in memory access");

  branchCarriesNoWrite: assert property (
    @(posedge clk) disable iff (reset)
    pcSource |-> !exMem.memWrite && !exMem.regWrite
  ) else $error("taken branch also writes memory or a register");

endmodule

/* logic/instructionFetch.sv */
// Fetch stage: program counter, next-address choice and the register into decode.

`timescale 1ns/1ps

`include "core_params.svh"

module instructionFetch (
  input  logic              clk,
  input  logic              reset,
  input  logic              pcSource,
  input  logic [31:0]       branchTarget,
  input  isaPkg::instrWordT instruction,
  output logic [31:0]       instructionAddress,
  output isaPkg::instrWordT instructionId,
  output logic [31:0]       pcPlus4Id
);

  logic [31:0] pc;
  logic [31:0] pcPlus4;
  logic [31:0] nextPc;

  assign pcPlus4 = pc + 32'd4;

  // Taken branch from memory access wins.
  assign nextPc = pcSource ? branchTarget : pcPlus4;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `CORE_RESET_PC;
    end else begin
      pc <= nextPc;
    end
  end

  assign instructionAddress = pc;

  // Fetch to decode register.
  always_ff @(posedge clk) begin
    if (reset) begin
      instructionId <= `CORE_NOP;
    end else begin
      instructionId <= instruction;
    end
  end

  always_ff @(posedge clk) begin
    pcPlus4Id <= pcPlus4;
  end

endmodule

/* logic/isaPkg.sv */
// Instruction set description: opcodes, function codes, instruction word views and ALU commands.

package isaPkg;

  // Major opcodes of the supported subset.
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_BEQ   = 6'h04,
    OP_ADDI  = 6'h08,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcodeT;

  // Function codes of the R-type words.
  typedef enum logic [5:0] {
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } functT;

  // Commands understood by the ALU.
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } aluCmdT;

  typedef struct packed {
    opcodeT     opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    functT      funct;
  } regFormT;

  typedef struct packed {
    opcodeT      opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } immFormT;

  // One fetched word, read as register form or immediate form.
  typedef union packed {
    regFormT register;
    immFormT immediate;
  } instrWordT;

endpackage

/* logic/pipePkg.sv */
// Pipeline description: the control bundle and the stage register layouts of the core.

package pipePkg;

  // Control levels produced by decode, 9 bits.
  typedef struct packed {
    logic            regWrite;
    logic            memToReg;
    logic            memWrite;
    logic            branch;
    isaPkg::aluCmdT  aluControl;
    logic            aluSrc;
    logic            regDst;
  } ctrlT;

  // Decode to execute.
  typedef struct packed {
    ctrlT        ctrl;
    logic [31:0] readData1;
    logic [31:0] readData2;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] signImm;
    logic [31:0] pcPlus4;
  } idExT;

  // Execute to memory access.
  typedef struct packed {
    logic        regWrite;
    logic        memToReg;
    logic        memWrite;
    logic        branch;
    logic        zero;
    logic [31:0] aluOut;
    logic [31:0] writeData;
    logic [4:0]  writeReg;
    logic [31:0] pcBranch;
  } exMemT;

  // Memory access to write-back.
  typedef struct packed {
    logic        regWrite;
    logic        memToReg;
    logic [31:0] aluOut;
    logic [31:0] readData;
    logic [4:0]  writeReg;
  } memWbT;

endpackage

/* logic/registerFile.sv */
// Register file with two combinational read ports and one write port with write-through.

`timescale 1ns/1ps

`include "core_params.svh"

module registerFile (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  readReg1,
  input  logic [4:0]  readReg2,
  output logic [31:0] readData1,
  output logic [31:0] readData2,
  input  logic        regWrite,
  input  logic [4:0]  writeReg,
  input  logic [31:0] writeData
);

  logic [31:0] registers [`CORE_REG_COUNT];

  // Register zero is never written.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CORE_REG_COUNT; i++) begin
        registers[i] <= '0;
      end
    end else if (regWrite && writeReg != 5'd0) begin
      registers[writeReg] <= writeData;
    end
  end

  // Write-through lets write-back and decode share a cycle.
  assign readData1 = (readReg1 == 5'd0) ? 32'd0 :
                     (regWrite && writeReg == readReg1) ? writeData :
                     registers[readReg1];

  assign readData2 = (readReg2 == 5'd0) ? 32'd0 :
                     (regWrite && writeReg == readReg2) ? writeData :
                     registers[readReg2];

  // Write-back must name a known register and value.
  writeIsKnown: assert property (
    @(posedge clk) disable iff (reset)
    regWrite |-> !$isunknown({writeReg, writeData})
  ) else $error("register write with unknown destination or data");

endmodule

/* project.f */
+incdir+logic
logic/isaPkg.sv
logic/pipePkg.sv
logic/decodeCtrlIfc.sv
logic/instructionFetch.sv
logic/controlDecoder.sv
logic/registerFile.sv
logic/executeUnit.sv
logic/cpu.sv
dv/cpuTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the core and its testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module cpuTb -o cpuTbSim

./obj_dir/cpuTbSim | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished without a reported failure"
